//--- common/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;

    localparam logic [XLEN-1:0] RESET_PC  = 32'h0000_0000;
    localparam logic [XLEN-1:0] EXIT_ADDR = 32'h0000_0044; // program end marker

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // funct3, alu group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3, branch group
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR // add, then clear bit 0
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        wb_sel_e   wb_sel;
        logic      rf_wen;
        logic      is_jump;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;      // B imm for branches, else the alu operand
    } ctrl_t;

endpackage

//--- files.f
common/rv_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/core_top.sv
test/clk_gen.sv
test/core_tb.sv

//--- hw/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic          clk,
    input  logic          rst_n,
    output logic          imem_req_o,
    output rv_pkg::word_t imem_addr_o,
    input  logic          imem_ack_i,
    input  rv_pkg::word_t imem_data_i,
    output logic          exit_o,
    output rv_pkg::word_t gp_o
);
    import rv_pkg::*;

    word_t inst;
    word_t pc;
    word_t next_pc;
    word_t wb_data;
    word_t rs1_data;
    word_t rs2_data;
    logic  exec_en;
    ctrl_t ctrl;

    fetch_unit fetch0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req_o  (imem_req_o),
        .imem_addr_o (imem_addr_o),
        .imem_ack_i  (imem_ack_i),
        .imem_data_i (imem_data_i),
        .next_pc_i   (next_pc),
        .inst_o      (inst),
        .pc_o        (pc),
        .exec_en_o   (exec_en),
        .exit_o      (exit_o)
    );

    decoder dec0 (
        .inst_i (inst),
        .ctrl_o (ctrl)
    );

    reg_file rf0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .exec_en_i  (exec_en),
        .ctrl_i     (ctrl),
        .wb_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    exec_unit exu0 (
        .ctrl_i     (ctrl),
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .next_pc_o  (next_pc),
        .wb_data_o  (wb_data)
    );

endmodule

//--- hw/decoder.sv
`timescale 1ns/1ns

module decoder (
    input  rv_pkg::word_t inst_i,
    output rv_pkg::ctrl_t ctrl_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;
    logic       op_legal;
    logic       imm_legal;

    function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // funct7 only alt for sub and sra
    assign op_legal = (funct7 == F7_BASE) ||
        (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
    assign imm_legal = (funct3 == F3_SLL)     ? (funct7 == F7_BASE) :
                       (funct3 == F3_SRL_SRA) ? (funct7 == F7_BASE || funct7 == F7_ALT) :
                       1'b1;

    always_comb begin
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.br_op   = BR_NONE;
        ctrl_o.op1_sel = OP1_RS1;
        ctrl_o.op2_sel = OP2_RS2;
        ctrl_o.wb_sel  = WB_ALU;
        ctrl_o.rf_wen  = 1'b0;
        ctrl_o.is_jump = 1'b0;
        ctrl_o.rs1     = inst_i[19:15];
        ctrl_o.rs2     = inst_i[24:20];
        ctrl_o.rd      = inst_i[11:7];
        ctrl_o.imm     = imm_i;
        case (opcode)
            OPC_OP: begin
                ctrl_o.alu_op = alu_from_f3(funct3, funct7[5]);
                ctrl_o.rf_wen = op_legal;
            end
            OPC_OP_IMM: begin
                // only srai takes the alt bit, addi never turns into sub
                ctrl_o.alu_op  = alu_from_f3(funct3, funct3 == F3_SRL_SRA && funct7[5]);
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.rf_wen  = imm_legal;
            end
            OPC_LUI: begin
                ctrl_o.op1_sel = OP1_ZERO;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.imm     = imm_u;
                ctrl_o.rf_wen  = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.imm     = imm_u;
                ctrl_o.rf_wen  = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl_o.imm = imm_b;
                case (funct3)
                    F3_BEQ:  ctrl_o.br_op = BR_BEQ;
                    F3_BNE:  ctrl_o.br_op = BR_BNE;
                    F3_BLT:  ctrl_o.br_op = BR_BLT;
                    F3_BGE:  ctrl_o.br_op = BR_BGE;
                    F3_BLTU: ctrl_o.br_op = BR_BLTU;
                    F3_BGEU: ctrl_o.br_op = BR_BGEU;
                    default: ctrl_o.br_op = BR_NONE; // 010/011 reserved
                endcase
            end
            OPC_JAL: begin
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.op2_sel = OP2_IMM;
                ctrl_o.imm     = imm_j;
                ctrl_o.wb_sel  = WB_PC4;
                ctrl_o.rf_wen  = 1'b1;
                ctrl_o.is_jump = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    ctrl_o.alu_op  = ALU_JALR;
                    ctrl_o.op2_sel = OP2_IMM;
                    ctrl_o.wb_sel  = WB_PC4;
                    ctrl_o.rf_wen  = 1'b1;
                    ctrl_o.is_jump = 1'b1;
                end
            end
            default: ; // unknown word, falls through as a no-op
        endcase
    end

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  rv_pkg::ctrl_t ctrl_i,
    input  rv_pkg::word_t pc_i,
    input  rv_pkg::word_t rs1_data_i,
    input  rv_pkg::word_t rs2_data_i,
    output rv_pkg::word_t next_pc_o,
    output rv_pkg::word_t wb_data_o
);
    import rv_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    word_t              op1;
    word_t              op2;
    word_t              alu_res;
    word_t              pc_plus4;
    logic [SHAMT_W-1:0] shamt;
    logic               br_taken;

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_RS1: op1 = rs1_data_i;
            OP1_PC:  op1 = pc_i;
            default: op1 = '0; // lui
        endcase
    end

    assign op2   = (ctrl_i.op2_sel == OP2_IMM) ? ctrl_i.imm : rs2_data_i;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_SUB:  alu_res = op1 - op2;
            ALU_AND:  alu_res = op1 & op2;
            ALU_OR:   alu_res = op1 | op2;
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SLL:  alu_res = op1 << shamt;
            ALU_SRL:  alu_res = op1 >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op1) >>> shamt);
            ALU_SLT:  alu_res = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_res = word_t'(op1 < op2);
            ALU_JALR: alu_res = (op1 + op2) & ~word_t'(1);
            default:  alu_res = op1 + op2;
        endcase
    end

    // compare straight on the register values
    always_comb begin
        case (ctrl_i.br_op)
            BR_BEQ:  br_taken = (rs1_data_i == rs2_data_i);
            BR_BNE:  br_taken = (rs1_data_i != rs2_data_i);
            BR_BLT:  br_taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BR_BGE:  br_taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BR_BLTU: br_taken = (rs1_data_i < rs2_data_i);
            BR_BGEU: br_taken = (rs1_data_i >= rs2_data_i);
            default: br_taken = 1'b0;
        endcase
    end

    assign pc_plus4  = pc_i + 32'd4;
    assign next_pc_o = br_taken       ? pc_i + ctrl_i.imm :
                       ctrl_i.is_jump ? alu_res :
                       pc_plus4;
    assign wb_data_o = (ctrl_i.wb_sel == WB_PC4) ? pc_plus4 : alu_res; // link addr for jumps

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic          clk,
    input  logic          rst_n,
    output logic          imem_req_o,
    output rv_pkg::word_t imem_addr_o,
    input  logic          imem_ack_i,
    input  rv_pkg::word_t imem_data_i,
    input  rv_pkg::word_t next_pc_i,
    output rv_pkg::word_t inst_o,
    output rv_pkg::word_t pc_o,
    output logic          exec_en_o,
    output logic          exit_o
);
    import rv_pkg::*;

    typedef enum logic [1:0] {REQ, WAIT_ACK, WAIT_RELEASE, EXEC} fetch_state_e;

    fetch_state_e state_q;
    word_t        pc_q;
    word_t        inst_q;
    logic         exit_q;
    logic         at_exit;

    assign at_exit = (pc_q == EXIT_ADDR);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= REQ;
            pc_q    <= RESET_PC;
            exit_q  <= 1'b0;
        end else begin
            exit_q <= at_exit;
            case (state_q)
                REQ: begin  // idle, also parks here at exit
                    if (!at_exit && !imem_ack_i)
                        state_q <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (imem_ack_i)
                        state_q <= WAIT_RELEASE;
                end
                WAIT_RELEASE: begin
                    if (!imem_ack_i)
                        state_q <= EXEC;
                end
                EXEC: begin
                    pc_q    <= next_pc_i;
                    state_q <= (next_pc_i == EXIT_ADDR) ? REQ : WAIT_ACK;
                end
                default: state_q <= REQ;
            endcase
        end
    end

    // instruction latch, first cycle of ack
    always_ff @(posedge clk) begin
        if (state_q == WAIT_ACK && imem_ack_i)
            inst_q <= imem_data_i;
    end

    assign imem_req_o  = (state_q == WAIT_ACK);
    assign imem_addr_o = pc_q;
    assign inst_o      = inst_q;
    assign pc_o        = pc_q;
    assign exec_en_o   = (state_q == EXEC);
    assign exit_o      = exit_q;

    // four-phase rule, core side
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o && !imem_ack_i |=> imem_req_o);
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        imem_req_o |=> $stable(imem_addr_o));

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          exec_en_i,
    input  rv_pkg::ctrl_t ctrl_i,
    input  rv_pkg::word_t wb_data_i,
    output rv_pkg::word_t rs1_data_o,
    output rv_pkg::word_t rs2_data_o,
    output rv_pkg::word_t gp_o
);
    import rv_pkg::*;

    word_t regs [1:REG_COUNT-1]; // no storage for x0
    logic  wr_en;

    assign wr_en = exec_en_i && ctrl_i.rf_wen && (ctrl_i.rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[ctrl_i.rd] <= wb_data_i;
        end
    end

    assign rs1_data_o = (ctrl_i.rs1 == '0) ? '0 : regs[ctrl_i.rs1];
    assign rs2_data_o = (ctrl_i.rs2 == '0) ? '0 : regs[ctrl_i.rs2];
    assign gp_o       = regs[3]; // x3

endmodule

//--- test/clk_gen.sv
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

//--- test/core_tb.sv
`timescale 1ns/1ns

module core_tb;
    import rv_pkg::*;

    localparam int MAX_TESTS  = 4;
    localparam int REC_W      = 20;  // number, budget, expected gp, 17 program words
    localparam int PROG_WORDS = 17;

    logic  clk;
    logic  rst_n;
    logic  imem_req;
    word_t imem_addr;
    logic  imem_ack;
    word_t imem_data;
    logic  exit_flag;
    word_t gp;

    word_t test_mem [0:MAX_TESTS*REC_W];
    word_t prog [0:PROG_WORDS-1];
    int    cycles;
    int    cycle_limit;
    int    delay;
    logic  pending;
    logic  prev_req;
    word_t prev_addr;

    clk_gen #(.PERIOD_NS(40)) clk0 (.clk_o(clk));

    core_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .imem_req_o  (imem_req),
        .imem_addr_o (imem_addr),
        .imem_ack_i  (imem_ack),
        .imem_data_i (imem_data),
        .exit_o      (exit_flag),
        .gp_o        (gp)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit != 0 && cycles >= cycle_limit)
            fail_now($sformatf("timeout after %0d cycles, program never reached exit", cycles));
    end

    // instruction memory plus handshake monitor, all on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (imem_req !== 1'b1)
            else fail_now("request raised while reset is asserted");
            imem_ack = 1'b0;
            pending  = 1'b0;
            prev_req = 1'b0;
        end else begin
            if (imem_req)
                assert (imem_addr[1:0] == 2'b00)
                else fail_now($sformatf("FAILED imem_addr_o[1:0]: got 0x%0h, expected 0x0",
                                        imem_addr[1:0]));
            if (prev_req && imem_req)
                assert (imem_addr == prev_addr)
                else fail_now($sformatf("FAILED imem_addr_o: got 0x%08h, expected 0x%08h",
                                        imem_addr, prev_addr));
            if (prev_req && !imem_req)
                assert (imem_ack) else fail_now("request dropped before acknowledge");
            if (!prev_req && imem_req)
                assert (!imem_ack) else fail_now("request raised while acknowledge still high");
            if (exit_flag)
                assert (!imem_req) else fail_now("request issued after exit was raised");

            if (imem_ack) begin
                if (!imem_req)
                    imem_ack = 1'b0;
            end else if (imem_req) begin
                if (!pending) begin
                    pending = 1'b1;
                    delay   = $urandom % 8;
                end
                if (delay == 0) begin
                    assert (imem_addr < EXIT_ADDR)
                    else fail_now($sformatf("fetch outside program area at 0x%08h", imem_addr));
                    imem_data = prog[imem_addr[6:2]];
                    imem_ack  = 1'b1;
                    pending   = 1'b0;
                end else begin
                    delay--;
                end
            end
            prev_req  = imem_req;
            prev_addr = imem_addr;
        end
    end

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (10) @(negedge clk);
        assert (exit_flag == 1'b0)
        else fail_now($sformatf("FAILED exit_o: got 0x%0h, expected 0x0", exit_flag));
        assert (gp == '0)
        else fail_now($sformatf("FAILED gp_o: got 0x%08h, expected 0x00000000", gp));
        rst_n = 1'b1;
    endtask

    initial begin
        int    n_tests;
        int    base;
        int    budget_sum;
        word_t expected;

        void'($urandom(32'hac0c_da70));
        rst_n       = 1'b0;
        imem_ack    = 1'b0;
        imem_data   = '0;
        cycles      = 0;
        cycle_limit = 0;
        pending     = 1'b0;
        prev_req    = 1'b0;
        prev_addr   = '0;
        $readmemh("test/core_tests.mem", test_mem);
        n_tests = test_mem[0];
        assert (n_tests > 0 && n_tests <= MAX_TESTS)
        else fail_now("test count in data file is out of range");

        budget_sum = 0;
        for (int t = 0; t < n_tests; t++)
            budget_sum += test_mem[1 + t*REC_W + 1];
        cycle_limit = budget_sum * 12 + 10 * n_tests;

        for (int t = 0; t < n_tests; t++) begin
            base = 1 + t*REC_W;
            assert (test_mem[base] == t + 1)
            else fail_now($sformatf("FAILED test number: got 0x%0h, expected 0x%0h",
                                    test_mem[base], t + 1));
            expected = test_mem[base + 2];
            for (int i = 0; i < PROG_WORDS; i++)
                prog[i] = test_mem[base + 3 + i];

            apply_reset();
            while (!imem_req) @(negedge clk);
            assert (imem_addr == RESET_PC)
            else fail_now($sformatf("FAILED imem_addr_o: got 0x%08h, expected 0x%08h",
                                    imem_addr, RESET_PC));
            while (!exit_flag) @(negedge clk);
            assert (imem_addr == EXIT_ADDR)
            else fail_now($sformatf("FAILED imem_addr_o: got 0x%08h, expected 0x%08h",
                                    imem_addr, EXIT_ADDR));
            assert (gp == expected)
            else fail_now($sformatf("FAILED gp_o: got 0x%08h, expected 0x%08h", gp, expected));

            repeat (20) begin  // core parked, gp must hold
                @(negedge clk);
                assert (gp == expected)
                else fail_now($sformatf("FAILED gp_o: got 0x%08h, expected 0x%08h",
                                        gp, expected));
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- test/core_tests.mem
// record: test number, step budget, expected gp, then 17 program words from address 0x00
// the first word is the number of records
4
1 14 FEDC9B30
123450B7 67808093 00001117 FFF0C213 40425293 01C25313
00831393 7F02F413 10036493 FFF2A513 FFF2B593 007101B3
008181B3 009181B3 00A181B3 00B181B3 0051C1B3
2 14 FEFF6F69
800000B7 12308093 00700113 401101B3 00209233 0020D2B3
4020D333 0020A3B3 0020B433 0060F4B3 00526533 00208033
00A1C1B3 009181B3 007181B3 008181B3 000181B3
3 10 00000004
FFF00093 00000463 10018193 00008463 00118193 00009463
10018193 00001463 00118193 0000C463 10018193 00104463
00118193 00105463 10018193 0000D463 00118193
4 10 00000063
FFF00093 00106463 10018193 0000E463 00118193 0000F463
10018193 00107463 00118193 00C002EF 10018193 10018193
1001818B 01128367 006181B3 005181B3 00118193
